//--- rtl/rs_pkg.sv
package rs_pkg;

    // Datapath and naming widths
    localparam int XLEN = 32;
    localparam int REG_W = 3;
    localparam int TAG_W = 4;
    localparam int IMM_W = 6;

    localparam int NUM_REGS = 1 << REG_W;
    localparam int NUM_TAGS = 1 << TAG_W;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_e;

    // Register-register form, fmt is 0
    typedef struct packed {
        alu_op_e            op;
        logic               fmt;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs1;
        logic [REG_W-1:0]   rs2;
        logic [2:0]         spare;
    } insn_r_t;

    // Immediate form, fmt is 1
    typedef struct packed {
        alu_op_e            op;
        logic               fmt;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs1;
        logic [IMM_W-1:0]   imm;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    // Tag is only meaningful while ready is low
    typedef struct packed {
        logic               ready;
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    value;
    } operand_t;

    typedef struct packed {
        alu_op_e            op;
        logic [TAG_W-1:0]   dest;
        operand_t           src1;
        operand_t           src2;
    } rs_op_t;

endpackage

//--- rtl/issue_if.sv
`timescale 1ns/1ns

interface issue_if #(
    parameter int RS_DEPTH = 4
);
    import rs_pkg::*;

    logic   iss_valid;
    rs_op_t iss_op;
    // One pulse for every station entry that is released
    logic   credit_return;

    // Dispatch can never hold more credits than the station has entries
    function automatic logic credit_in_range(input int unsigned count);
        return count <= RS_DEPTH;
    endfunction

    modport dispatch (
        output iss_valid,
        output iss_op,
        input  credit_return,
        import credit_in_range
    );

    modport station (
        input  iss_valid,
        input  iss_op,
        output credit_return
    );

endinterface

//--- rtl/dispatch_unit.sv
`timescale 1ns/1ns

module dispatch_unit #(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        insn_valid_i,
    input  rs_pkg::insn_u               insn_i,
    output logic                        insn_ready_o,
    input  logic                        cdb_valid_i,
    input  logic [rs_pkg::TAG_W-1:0]    cdb_tag_i,
    input  logic [rs_pkg::XLEN-1:0]     cdb_value_i,
    input  logic [rs_pkg::REG_W-1:0]    reg_addr_i,
    output logic [rs_pkg::XLEN-1:0]     reg_data_o,
    issue_if.dispatch                   iss
);
    import rs_pkg::*;

    localparam int CREDIT_W = $clog2(RS_DEPTH + 1);

    logic [XLEN-1:0]     regs_q [NUM_REGS];
    logic [NUM_REGS-1:0] pending_q;
    logic [TAG_W-1:0]    pend_tag_q [NUM_REGS];
    logic [NUM_TAGS-1:0] inflight_q;
    logic [TAG_W-1:0]    next_tag_q;
    logic [CREDIT_W-1:0] credits_q;

    logic             accept;
    alu_op_e          op;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic             use_imm;
    logic [XLEN-1:0]  imm_ext;
    operand_t         src1;
    operand_t         src2;

    // Register value, or the pending tag unless the CDB delivers it right now
    function automatic operand_t read_src(input logic [REG_W-1:0] idx);
        operand_t o;
        o.ready = 1'b1;
        o.tag = pend_tag_q[idx];
        o.value = regs_q[idx];
        if (pending_q[idx]) begin
            if (cdb_valid_i && cdb_tag_i == pend_tag_q[idx]) begin
                o.value = cdb_value_i;
            end else begin
                o.ready = 1'b0;
            end
        end
        return o;
    endfunction

    assign insn_ready_o = (credits_q != '0) && !inflight_q[next_tag_q];
    assign accept = insn_valid_i && insn_ready_o;
    assign reg_data_o = regs_q[reg_addr_i];

    // fmt sits in the same bit in both views
    always_comb begin
        if (insn_i.r.fmt == 1'b0) begin
            op = insn_i.r.op;
            rd = insn_i.r.rd;
            rs1 = insn_i.r.rs1;
            rs2 = insn_i.r.rs2;
            use_imm = 1'b0;
            imm_ext = '0;
        end else begin
            op = insn_i.i.op;
            rd = insn_i.i.rd;
            rs1 = insn_i.i.rs1;
            rs2 = '0;
            use_imm = 1'b1;
            imm_ext = {{(XLEN - IMM_W){insn_i.i.imm[IMM_W-1]}}, insn_i.i.imm};
        end
        src1 = read_src(rs1);
        if (use_imm) begin
            src2.ready = 1'b1;
            src2.tag = '0;
            src2.value = imm_ext;
        end else begin
            src2 = read_src(rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
                pend_tag_q[r] <= '0;
            end
            pending_q <= '0;
            inflight_q <= '0;
            next_tag_q <= '0;
            credits_q <= CREDIT_W'(RS_DEPTH);
            iss.iss_valid <= 1'b0;
        end else begin
            iss.iss_valid <= accept;

            // Result lands only if its tag is still the newest for that register
            for (int r = 1; r < NUM_REGS; r++) begin
                if (cdb_valid_i && pending_q[r] && pend_tag_q[r] == cdb_tag_i) begin
                    regs_q[r] <= cdb_value_i;
                    pending_q[r] <= 1'b0;
                end
            end
            if (cdb_valid_i) begin
                inflight_q[cdb_tag_i] <= 1'b0;
            end

            if (accept) begin
                inflight_q[next_tag_q] <= 1'b1;
                next_tag_q <= next_tag_q + 1'b1;
                // r0 stays constant zero
                if (rd != '0) begin
                    pending_q[rd] <= 1'b1;
                    pend_tag_q[rd] <= next_tag_q;
                end
            end

            if (accept && !iss.credit_return) begin
                credits_q <= credits_q - 1'b1;
            end else if (!accept && iss.credit_return) begin
                credits_q <= credits_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss.iss_op <= '{op: op, dest: next_tag_q, src1: src1, src2: src2};
        end
    end

    a_credit_range: assert property (@(posedge clk) disable iff (rst_i)
        iss.credit_in_range(credits_q));

    // Every broadcast must belong to an instruction still waiting for it
    a_cdb_inflight: assert property (@(posedge clk) disable iff (rst_i)
        cdb_valid_i |-> inflight_q[cdb_tag_i]);

endmodule

//--- rtl/reservation_station.sv
`timescale 1ns/1ns

module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_i,
    issue_if.station                    iss,
    input  logic                        cdb_valid_i,
    input  logic [rs_pkg::TAG_W-1:0]    cdb_tag_i,
    input  logic [rs_pkg::XLEN-1:0]     cdb_value_i,
    output logic                        alu_valid_o,
    output rs_pkg::rs_op_t              alu_op_o
);
    import rs_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    rs_op_t              ent_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy_q;
    logic [RS_DEPTH-1:0] ready_vec;
    logic [IDX_W-1:0]    free_idx;
    logic [IDX_W-1:0]    issue_idx;
    logic                issue_fire;
    rs_op_t              incoming;

    // Pick up a broadcast value for an operand that waits on it
    function automatic operand_t snoop(input operand_t o);
        operand_t r;
        r = o;
        if (!o.ready && cdb_valid_i && o.tag == cdb_tag_i) begin
            r.ready = 1'b1;
            r.value = cdb_value_i;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_vec[i] = busy_q[i] && ent_q[i].src1.ready && ent_q[i].src2.ready;
        end
    end

    // Scan from the top so the lowest index wins
    always_comb begin
        free_idx = '0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready_vec[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign issue_fire = |ready_vec;
    assign iss.credit_return = issue_fire;

    // Operation being written also sees the CDB of its capture cycle
    always_comb begin
        incoming = iss.iss_op;
        incoming.src1 = snoop(iss.iss_op.src1);
        incoming.src2 = snoop(iss.iss_op.src2);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= '0;
            alu_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= issue_fire;
            if (issue_fire) begin
                busy_q[issue_idx] <= 1'b0;
            end
            // A free slot is never the issuing one
            if (iss.iss_valid) begin
                busy_q[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (iss.iss_valid && free_idx == IDX_W'(i)) begin
                ent_q[i] <= incoming;
            end else begin
                ent_q[i].src1 <= snoop(ent_q[i].src1);
                ent_q[i].src2 <= snoop(ent_q[i].src2);
            end
        end
        if (issue_fire) begin
            alu_op_o <= ent_q[issue_idx];
        end
    end

    // Credits upstream should make a full station unreachable
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        iss.iss_valid |-> !(&busy_q));

endmodule

//--- rtl/alu_pipe.sv
`timescale 1ns/1ns

module alu_pipe (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        alu_valid_i,
    input  rs_pkg::rs_op_t              alu_op_i,
    output logic                        cdb_valid_o,
    output logic [rs_pkg::TAG_W-1:0]    cdb_tag_o,
    output logic [rs_pkg::XLEN-1:0]     cdb_value_o
);
    import rs_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  result;
    logic             s1_valid_q;
    logic [TAG_W-1:0] s1_tag_q;
    logic [XLEN-1:0]  s1_result_q;

    assign a = alu_op_i.src1.value;
    assign b = alu_op_i.src2.value;

    always_comb begin
        case (alu_op_i.op)
            ADD: result = a + b;
            SUB: result = a - b;
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            // Shift amount from the low bits only
            SLL: result = a << b[SHAMT_W-1:0];
            SRL: result = a >> b[SHAMT_W-1:0];
            SLT: result = {{(XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
            cdb_valid_o <= 1'b0;
        end else begin
            s1_valid_q <= alu_valid_i;
            cdb_valid_o <= s1_valid_q;
        end
    end

    // Stage one holds the result, stage two drives the CDB
    always_ff @(posedge clk) begin
        s1_tag_q <= alu_op_i.dest;
        s1_result_q <= result;
        cdb_tag_o <= s1_tag_q;
        cdb_value_o <= s1_result_q;
    end

    // Station must only hand over fully resolved operations
    a_operands_ready: assert property (@(posedge clk) disable iff (rst_i)
        alu_valid_i |-> alu_op_i.src1.ready && alu_op_i.src2.ready);

endmodule

//--- rtl/rs_top.sv
`timescale 1ns/1ns

module rs_top #(
    parameter int RS_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        insn_valid_i,
    input  logic [15:0]                 insn_i,
    output logic                        insn_ready_o,
    output logic                        cdb_valid_o,
    output logic [rs_pkg::TAG_W-1:0]    cdb_tag_o,
    output logic [rs_pkg::XLEN-1:0]     cdb_value_o,
    input  logic [rs_pkg::REG_W-1:0]    reg_addr_i,
    output logic [rs_pkg::XLEN-1:0]     reg_data_o
);
    import rs_pkg::*;

    insn_u  insn_w;
    logic   alu_valid;
    rs_op_t alu_op;

    assign insn_w = insn_i;

    issue_if #(.RS_DEPTH(RS_DEPTH)) iss_bus ();

    dispatch_unit #(.RS_DEPTH(RS_DEPTH)) u_dispatch (
        .clk          (clk),
        .rst_i        (rst_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_w),
        .insn_ready_o (insn_ready_o),
        .cdb_valid_i  (cdb_valid_o),
        .cdb_tag_i    (cdb_tag_o),
        .cdb_value_i  (cdb_value_o),
        .reg_addr_i   (reg_addr_i),
        .reg_data_o   (reg_data_o),
        .iss          (iss_bus.dispatch)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_station (
        .clk          (clk),
        .rst_i        (rst_i),
        .iss          (iss_bus.station),
        .cdb_valid_i  (cdb_valid_o),
        .cdb_tag_i    (cdb_tag_o),
        .cdb_value_i  (cdb_value_o),
        .alu_valid_o  (alu_valid),
        .alu_op_o     (alu_op)
    );

    // CDB is shared by the outputs, dispatch and the station
    alu_pipe u_alu (
        .clk          (clk),
        .rst_i        (rst_i),
        .alu_valid_i  (alu_valid),
        .alu_op_i     (alu_op),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o)
    );

endmodule

//--- tests/rs_tb.sv
`timescale 1ns/1ns

module rs_tb;
    import rs_pkg::*;

    localparam int RS_DEPTH = 4;
    localparam int NUM_ROWS = 25;
    localparam int PASSES = 2;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * PASSES * 30;
    localparam int DRAIN_CYCLES = 100;

    logic             clk;
    logic             rst_i;
    logic             insn_valid_i;
    logic [15:0]      insn_i;
    logic             insn_ready_o;
    logic             cdb_valid_o;
    logic [TAG_W-1:0] cdb_tag_o;
    logic [XLEN-1:0]  cdb_value_o;
    logic [REG_W-1:0] reg_addr_i;
    logic [XLEN-1:0]  reg_data_o;

    // Program rows with hand-computed results
    logic [15:0]      insn_tab [NUM_ROWS];
    logic [XLEN-1:0]  exp_tab [NUM_ROWS];
    int               row_count;

    // Which global instruction currently owns each tag
    bit               outstanding [NUM_TAGS];
    int               owner [NUM_TAGS];
    int               issued_count;
    int               done_count;
    int               stall_cycles;
    logic [XLEN-1:0]  ref_regs [NUM_REGS];

    rs_top #(.RS_DEPTH(RS_DEPTH)) UUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .insn_ready_o (insn_ready_o),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o),
        .reg_addr_i   (reg_addr_i),
        .reg_data_o   (reg_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] encode_r(input alu_op_e op, input logic [REG_W-1:0] rd,
                                             input logic [REG_W-1:0] rs1,
                                             input logic [REG_W-1:0] rs2);
        return {op, 1'b0, rd, rs1, rs2, 3'b000};
    endfunction

    function automatic logic [15:0] encode_i(input alu_op_e op, input logic [REG_W-1:0] rd,
                                             input logic [REG_W-1:0] rs1,
                                             input logic [IMM_W-1:0] imm);
        return {op, 1'b1, rd, rs1, imm};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_cdb(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail cdb_value_o (cdb_tag_o %h): got %h expected %h",
                                tag, got, exp));
        end
    endtask

    task automatic check_reg(input logic [REG_W-1:0] idx, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail reg_data_o (reg_addr_i %h): got %h expected %h",
                                idx, got, exp));
        end
    endtask

    task automatic add_row(input logic [15:0] word, input logic [XLEN-1:0] exp);
        insn_tab[row_count] = word;
        exp_tab[row_count] = exp;
        row_count++;
    endtask

    // Every register read is written earlier in the table, so both passes agree
    task automatic load_table();
        row_count = 0;
        // Immediates into distinct registers
        add_row(encode_i(ADD, 3'd1, 3'd0, 6'h05), 32'h0000_0005);
        add_row(encode_i(ADD, 3'd2, 3'd0, 6'h3d), 32'hffff_fffd);
        add_row(encode_i(ADD, 3'd3, 3'd0, 6'h1f), 32'h0000_001f);
        add_row(encode_i(OR,  3'd4, 3'd0, 6'h12), 32'h0000_0012);
        // All operations, shift amounts come from the low five bits
        add_row(encode_r(SUB, 3'd5, 3'd1, 3'd2), 32'h0000_0008);
        add_row(encode_r(AND, 3'd6, 3'd2, 3'd3), 32'h0000_001d);
        add_row(encode_r(XOR, 3'd7, 3'd2, 3'd4), 32'hffff_ffef);
        add_row(encode_r(SLL, 3'd5, 3'd1, 3'd3), 32'h8000_0000);
        add_row(encode_r(SRL, 3'd6, 3'd2, 3'd2), 32'h0000_0007);
        add_row(encode_r(SLT, 3'd7, 3'd2, 3'd1), 32'h0000_0001);
        add_row(encode_r(SLT, 3'd7, 3'd1, 3'd2), 32'h0000_0000);
        add_row(encode_i(SLL, 3'd1, 3'd1, 6'h22), 32'h0000_0014);
        // Dependent chain through r2
        add_row(encode_i(ADD, 3'd2, 3'd1, 6'h01), 32'h0000_0015);
        add_row(encode_i(SUB, 3'd2, 3'd2, 6'h3f), 32'h0000_0016);
        add_row(encode_i(XOR, 3'd2, 3'd2, 6'h0f), 32'h0000_0019);
        add_row(encode_i(SLL, 3'd2, 3'd2, 6'h04), 32'h0000_0190);
        // Older write to r7 waits on the chain while the younger one is independent
        add_row(encode_r(ADD, 3'd7, 3'd2, 3'd2), 32'h0000_0320);
        add_row(encode_i(ADD, 3'd7, 3'd0, 6'h07), 32'h0000_0007);
        // Burst of readers waiting on the end of the chain
        add_row(encode_r(ADD, 3'd3, 3'd2, 3'd0), 32'h0000_0190);
        add_row(encode_i(OR,  3'd4, 3'd2, 6'h01), 32'h0000_0191);
        add_row(encode_i(SRL, 3'd5, 3'd2, 6'h04), 32'h0000_0019);
        add_row(encode_i(AND, 3'd0, 3'd2, 6'h1f), 32'h0000_0010);
        add_row(encode_r(SUB, 3'd6, 3'd0, 3'd2), 32'hffff_fe70);
        // Write to r0 is dropped
        add_row(encode_i(ADD, 3'd1, 3'd0, 6'h3f), 32'hffff_ffff);
        add_row(encode_r(ADD, 3'd0, 3'd1, 3'd1), 32'hffff_fffe);
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_insn(input logic [15:0] word, input int g);
        logic [TAG_W-1:0] tag;
        tag = TAG_W'(g);
        insn_i = word;
        insn_valid_i = 1'b1;
        while (!insn_ready_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        if (outstanding[tag]) begin
            abort_run($sformatf("Instruction %0d was accepted while tag %0d was in flight",
                                g, tag));
        end
        outstanding[tag] = 1'b1;
        owner[tag] = g;
        issued_count++;
        @(negedge clk);
        insn_valid_i = 1'b0;
    endtask

    // CDB holds for a whole cycle, so the falling edge sees each broadcast once
    always @(negedge clk) begin
        if (!rst_i && cdb_valid_o) begin
            if (!outstanding[cdb_tag_o]) begin
                abort_run($sformatf("CDB broadcast tag %0d with no instruction waiting on it",
                                    cdb_tag_o));
            end else begin
                check_cdb(cdb_tag_o, cdb_value_o, exp_tab[owner[cdb_tag_o] % NUM_ROWS]);
                outstanding[cdb_tag_o] = 1'b0;
                done_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles without finishing", WATCHDOG_CYCLES));
    end

    initial begin : main
        int               gap;
        int               g;
        logic [REG_W-1:0] rd;

        void'($urandom(32'hc615baed));
        rst_i = 1'b1;
        insn_valid_i = 1'b0;
        insn_i = '0;
        reg_addr_i = '0;
        issued_count = 0;
        done_count = 0;
        stall_cycles = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
            owner[t] = 0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // First pass back to back, second pass with random idle gaps
        g = 0;
        for (int pass = 0; pass < PASSES; pass++) begin
            for (int row = 0; row < NUM_ROWS; row++) begin
                if (pass == 1) begin
                    gap = $urandom % 4;
                    repeat (gap) @(negedge clk);
                end
                send_insn(insn_tab[row], g);
                g++;
            end
        end

        for (int c = 0; c < DRAIN_CYCLES && done_count != issued_count; c++) begin
            @(negedge clk);
        end

        if (stall_cycles == 0) begin
            abort_run("insn_ready_o never dropped while the burst waited on the chain");
        end

        // Reference register file from the table in program order
        for (int r = 0; r < NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        for (int pass = 0; pass < PASSES; pass++) begin
            for (int row = 0; row < NUM_ROWS; row++) begin
                rd = insn_tab[row][11:9];
                if (rd != '0) begin
                    ref_regs[rd] = exp_tab[row];
                end
            end
        end

        if (done_count != issued_count) begin
            $display("Missing broadcast: only %0d of %0d instructions reached the CDB",
                     done_count, issued_count);
            $display("Regression failed");
            $fatal(1);
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                @(negedge clk);
                reg_addr_i = REG_W'(r);
                #1;
                check_reg(REG_W'(r), reg_data_o, ref_regs[r]);
            end
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- rs_slice.f
rtl/rs_pkg.sv
rtl/issue_if.sv
rtl/dispatch_unit.sv
rtl/reservation_station.sv
rtl/alu_pipe.sv
rtl/rs_top.sv
tests/rs_tb.sv
